/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_pixel_path
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
ERR_LIMIT  ?= 10
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axis_skid_slice.sv */
module axis_skid_slice (
  input  logic                     aclk,
  input  logic                     rst_n,
  pix_beat_if.snk                  beat,
  output logic                     out_valid,
  input  logic                     out_ready,
  output cnn_pixel_pkg::pix_beat_t out_data,
  output cnn_pixel_pkg::pix_user_t out_user
);
  import cnn_pixel_pkg::*;

  logic      ready_r;
  logic      in_xfer;
  logic      main_valid;
  logic      main_free;
  logic      skid_valid;
  logic      skid_next;
  logic      main_next;
  pix_beat_t main_data;
  pix_user_t main_user;
  pix_beat_t skid_data;
  pix_user_t skid_user;

  assign beat.ready = ready_r;
  assign in_xfer    = beat.valid & ready_r;
  assign main_free  = out_ready | ~main_valid;  // main register empties or is empty

  // ready can only be high while the skid register is empty
  always_comb begin
    skid_next = skid_valid;
    main_next = main_valid;
    if (main_free) begin
      if (skid_valid) begin
        main_next = 1'b1;
        skid_next = 1'b0;
      end else begin
        main_next = in_xfer;
      end
    end else if (in_xfer) begin
      skid_next = 1'b1;  // beat was in flight when the output stalled
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_r    <= 1'b0;
    end else begin
      main_valid <= main_next;
      skid_valid <= skid_next;
      ready_r    <= ~skid_next;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) begin
      if (skid_valid) begin
        main_data <= skid_data;
        main_user <= skid_user;
      end else if (in_xfer) begin
        main_data <= beat.data;
        main_user <= beat.user;
      end
    end else if (in_xfer) begin
      skid_data <= beat.data;
      skid_user <= beat.user;
    end
  end

  assign out_valid = main_valid;
  assign out_data  = main_data;
  assign out_user  = main_user;

endmodule

/* cnn_pixel_pkg.sv */
package cnn_pixel_pkg;

  // pixel datapath widths
  localparam int WORD_WIDTH = 8;
  localparam int UNITS      = 2;  // words seen by one group of processing units
  localparam int COPIES     = 2;
  localparam int KH_MAX     = 3;

  // enough words so every group can slide down by KH_MAX-1
  localparam int IM_SHIFT_REGS = COPIES * UNITS + KH_MAX - 1;

  localparam int BITS_KH     = $clog2(KH_MAX);
  localparam int BITS_GATHER = $clog2(IM_SHIFT_REGS);

  // user bits that ride along with every bundle
  localparam int TUSER_WIDTH = 4;
  localparam int I_IS_MAX    = 0;
  localparam int I_IS_LRELU  = 1;

  typedef logic [WORD_WIDTH-1:0] pix_word_t;

  typedef logic [TUSER_WIDTH-1:0] pix_user_t;

  typedef logic [BITS_KH-1:0] kh_count_t;

  // word 0 sits in the lowest bits
  typedef logic [IM_SHIFT_REGS-1:0][WORD_WIDTH-1:0] pix_bundle_t;

  // indexed as [copy][unit]
  typedef logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] pix_beat_t;

endpackage

/* compile.f */
cnn_pixel_pkg.sv
pix_bundle_if.sv
pix_beat_if.sv
pixel_word_gather.sv
pixels_shift.sv
axis_skid_slice.sv
pixel_path_top.sv
pixel_path_checker.sv
tb_pixel_path.sv

/* pix_beat_if.sv */
interface pix_beat_if;
  import cnn_pixel_pkg::*;

  logic      valid;
  logic      ready;  // also the clock enable of the shifter
  pix_beat_t data;
  pix_user_t user;

  modport src (
    output valid,
    input  ready,
    output data,
    output user
  );

  modport snk (
    input  valid,
    output ready,
    input  data,
    input  user
  );

endinterface

/* pix_bundle_if.sv */
interface pix_bundle_if;
  import cnn_pixel_pkg::*;

  logic        valid;
  logic        ready;
  pix_bundle_t bundle;
  pix_user_t   user;
  kh_count_t   shift;  // number of extra beats after the first
  logic        ones;

  modport src (
    output valid,
    input  ready,
    output bundle,
    output user,
    output shift,
    output ones
  );

  modport snk (
    input  valid,
    output ready,
    input  bundle,
    input  user,
    input  shift,
    input  ones
  );

endinterface

/* pixel_path_checker.sv */
module pixel_path_checker (
  input logic                     aclk,
  input logic                     rst_n,
  input logic                     in_ready,
  input logic                     out_valid,
  input logic                     out_ready,
  input cnn_pixel_pkg::pix_beat_t out_data,
  input cnn_pixel_pkg::pix_user_t out_user
);
  timeunit 1ns;
  timeprecision 1ps;

  logic reset_fail = 1'b0;
  logic ready_fail = 1'b0;
  logic hold_fail  = 1'b0;
  logic drop_fail  = 1'b0;
  logic failed;

  assign failed = reset_fail | ready_fail | hold_fail | drop_fail;  // read by the testbench

  // the reset is synchronous, so outputs are low one edge after rst_n is seen low
  out_valid_in_reset: assert property (@(posedge aclk) !rst_n |=> !out_valid)
    else begin
      $error("out_valid is high after a reset edge");
      reset_fail = 1'b1;
    end

  in_ready_in_reset: assert property (@(posedge aclk) !rst_n |=> !in_ready)
    else begin
      $error("in_ready is high after a reset edge");
      ready_fail = 1'b1;
    end

  out_hold_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_user)))
    else begin
      $error("out_data or out_user changed while the output was stalled");
      hold_fail = 1'b1;
    end

  out_valid_no_drop: assert property (@(posedge aclk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> out_valid)
    else begin
      $error("out_valid dropped without a transfer");
      drop_fail = 1'b1;
    end

endmodule

bind pixel_path_top pixel_path_checker pixel_path_checker_i (
  .aclk      (aclk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .out_user  (out_user)
);

/* pixel_path_top.sv */
module pixel_path_top (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  cnn_pixel_pkg::pix_word_t in_data,
  input  cnn_pixel_pkg::pix_user_t in_user,
  input  cnn_pixel_pkg::kh_count_t in_shift,
  input  logic                     in_ones,
  output logic                     out_valid,
  input  logic                     out_ready,
  output cnn_pixel_pkg::pix_beat_t out_data,
  output cnn_pixel_pkg::pix_user_t out_user
);

  pix_bundle_if bundle_if ();
  pix_beat_if   beat_if ();

  // serial words into one bundle of shift registers
  pixel_word_gather pixel_word_gather_i (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .in_user  (in_user),
    .in_shift (in_shift),
    .in_ones  (in_ones),
    .bundle   (bundle_if.src)
  );

  // shift+1 beats per bundle, split into copy groups
  pixels_shift pixels_shift_i (
    .aclk   (aclk),
    .rst_n  (rst_n),
    .bundle (bundle_if.snk),
    .beat   (beat_if.src)
  );

  axis_skid_slice axis_skid_slice_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .beat      (beat_if.snk),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_user  (out_user)
  );

endmodule

/* pixel_word_gather.sv */
module pixel_word_gather (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  cnn_pixel_pkg::pix_word_t in_data,
  input  cnn_pixel_pkg::pix_user_t in_user,
  input  cnn_pixel_pkg::kh_count_t in_shift,
  input  logic                     in_ones,
  pix_bundle_if.src                bundle
);
  import cnn_pixel_pkg::*;

  logic [BITS_GATHER-1:0] word_cnt;
  logic                   last_word;
  logic                   running;
  logic                   full;
  logic                   in_xfer;
  pix_bundle_t            words;
  pix_user_t              user_r;
  kh_count_t              shift_r;
  logic                   ones_r;

  assign last_word = (word_cnt == BITS_GATHER'(IM_SHIFT_REGS - 1));
  assign in_ready  = running & ~full;  // single bundle buffer, no overlap with the handoff
  assign in_xfer   = in_valid & in_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      running  <= 1'b0;
      full     <= 1'b0;
      word_cnt <= '0;
    end else begin
      running <= 1'b1;  // keeps in_ready low for the reset cycles
      if (in_xfer) begin
        if (last_word) begin
          word_cnt <= '0;
          full     <= 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end else if (full && bundle.ready) begin
        full <= 1'b0;
      end
    end
  end

  // slots and sideband are only written while the buffer is empty
  always_ff @(posedge aclk) begin
    if (in_xfer) begin
      words[word_cnt] <= in_data;
      if (last_word) begin
        user_r  <= in_user;
        shift_r <= in_shift;
        ones_r  <= in_ones;
      end
    end
  end

  assign bundle.valid  = full;
  assign bundle.bundle = words;
  assign bundle.user   = user_r;
  assign bundle.shift  = shift_r;
  assign bundle.ones   = ones_r;

endmodule

/* pixels_shift.sv */
module pixels_shift (
  input  logic      aclk,
  input  logic      rst_n,
  pix_bundle_if.snk bundle,
  pix_beat_if.src   beat
);
  import cnn_pixel_pkg::*;

  logic        clken;
  logic        count_last;
  logic        count_en;
  kh_count_t   count;
  pix_bundle_t words;
  logic        valid_r;
  pix_user_t   user_r;
  logic        ones_r;
  logic        split;
  pix_beat_t   groups;

  assign clken = beat.ready;  // downstream stall freezes the whole stage

  // at zero a new bundle may be loaded, otherwise keep sliding the held one
  assign count_last   = (count == '0);
  assign count_en     = clken & (count_last ? bundle.valid : 1'b1);
  assign bundle.ready = clken & count_last;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      count <= '0;
      words <= '0;
    end else if (count_en) begin
      if (count_last) begin
        count <= bundle.shift;
        words <= bundle.bundle;
      end else begin
        count <= count - 1'b1;
        words <= words >> WORD_WIDTH;  // zero words enter from the top
      end
    end
  end

  // valid only changes at a bundle boundary and stays up while sliding
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_r <= 1'b0;
    end else if (bundle.ready) begin
      valid_r <= bundle.valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (bundle.valid && bundle.ready) begin
      user_r <= bundle.user;
      ones_r <= bundle.ones;
    end
  end

  // max-pool needs a separate window per copy, every other mode broadcasts group 0
  assign split = user_r[I_IS_MAX] & ~ones_r;

  always_comb begin
    for (int c = 0; c < COPIES; c++) begin
      if (split) begin
        groups[c] = words[c*UNITS +: UNITS];
      end else begin
        groups[c] = words[UNITS-1:0];
      end
    end
  end

  assign beat.valid = valid_r;
  assign beat.data  = groups;
  assign beat.user  = user_r;

endmodule

/* tb_pixel_path.sv */
module tb_pixel_path;
  timeunit 1ns;
  timeprecision 1ps;
  import cnn_pixel_pkg::*;

  localparam int          NUM_BUNDLES  = 64;
  localparam int          RESET_CYCLES = 16;
  localparam int          HALF_PERIOD  = 50;
  localparam int          DRAIN_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'h70de_e76c;

  logic      aclk;
  logic      rst_n;
  logic      in_valid;
  logic      in_ready;
  pix_word_t in_data;
  pix_user_t in_user;
  kh_count_t in_shift;
  logic      in_ones;
  logic      out_valid;
  logic      out_ready;
  pix_beat_t out_data;
  pix_user_t out_user;

  pix_bundle_t bundle_words [NUM_BUNDLES];
  pix_user_t   bundle_user [NUM_BUNDLES];
  kh_count_t   bundle_shift [NUM_BUNDLES];
  logic        bundle_ones [NUM_BUNDLES];

  pix_beat_t exp_data_q [$];
  pix_user_t exp_user_q [$];

  logic [31:0] rng;
  int          cycles = 0;
  int          cycle_limit = 0;

  pixel_path_top pixel_path_top_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_user   (in_user),
    .in_shift  (in_shift),
    .in_ones   (in_ones),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_user  (out_user)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // beat k of a bundle, words past the end of the bundle read as zero
  function automatic pix_beat_t expected_beat(input pix_bundle_t w, input int k,
                                              input logic split);
    pix_beat_t b;
    int        idx;
    for (int c = 0; c < COPIES; c++) begin
      for (int u = 0; u < UNITS; u++) begin
        idx = split ? k + c * UNITS + u : k + u;
        b[c][u] = (idx < IM_SHIFT_REGS) ? w[idx] : '0;
      end
    end
    return b;
  endfunction

  task automatic build_stimulus();
    logic split;
    for (int n = 0; n < NUM_BUNDLES; n++) begin
      for (int i = 0; i < IM_SHIFT_REGS; i++) begin
        rng = xorshift32(rng);
        bundle_words[n][i] = rng[WORD_WIDTH-1:0];
      end
      rng = xorshift32(rng);
      bundle_user[n]  = rng[TUSER_WIDTH-1:0];
      bundle_shift[n] = kh_count_t'(rng[15:8] % KH_MAX);
      bundle_ones[n]  = (rng[17:16] == 2'b00);  // ones mode about one bundle in four
      split = bundle_user[n][I_IS_MAX] & ~bundle_ones[n];
      for (int k = 0; k <= int'(bundle_shift[n]); k++) begin
        exp_data_q.push_back(expected_beat(bundle_words[n], k, split));
        exp_user_q.push_back(bundle_user[n]);
      end
    end
  endtask

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // compare one output transfer with the oldest expected beat
  task automatic check_output_beat();
    pix_beat_t exp_data;
    pix_user_t exp_user;
    assert (exp_data_q.size() != 0) else begin
      $display("ERR %0t: output beat arrived with no beat expected", $time);
      stop_on_error();
    end
    exp_data = exp_data_q.pop_front();
    exp_user = exp_user_q.pop_front();
    assert (out_data == exp_data) else begin
      $display("ERR %0t: out_data %h, expected %h", $time, out_data, exp_data);
      stop_on_error();
    end
    assert (out_user == exp_user) else begin
      $display("ERR %0t: out_user %h, expected %h", $time, out_user, exp_user);
      stop_on_error();
    end
  endtask

  initial begin
    aclk = 1'b0;
    forever #HALF_PERIOD aclk = ~aclk;
  end

  always @(posedge aclk) begin
    if (rst_n && out_valid && out_ready) begin
      check_output_beat();
    end
  end

  // checker flags and the timeout are looked at away from the rising edge
  always @(negedge aclk) begin
    cycles++;
    if (pixel_path_top_i.pixel_path_checker_i.failed) begin
      $display("a protocol assertion on the DUT ports failed");
      stop_on_error();
    end else if (exp_data_q.size() != 0 && cycles > cycle_limit) begin
      $display("timeout: outputs stopped arriving with %0d beats still expected",
               exp_data_q.size());
      stop_on_error();
    end
  end

  initial begin
    int   n;
    int   w;
    logic took_word;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    in_user   = '0;
    in_shift  = '0;
    in_ones   = 1'b0;
    out_ready = 1'b0;
    rng       = SEED;
    build_stimulus();
    cycle_limit = 8 * exp_data_q.size() + 200;
    repeat (RESET_CYCLES) @(negedge aclk);
    rst_n = 1'b1;
    @(negedge aclk);
    assert (in_ready && !out_valid) else begin
      $display("ERR %0t: in_ready %b out_valid %b one cycle after reset", $time,
               in_ready, out_valid);
      stop_on_error();
    end
    n = 0;
    w = 0;
    took_word = 1'b0;
    while (exp_data_q.size() != 0) begin
      if (took_word) begin
        in_valid = 1'b0;
      end
      rng = xorshift32(rng);
      out_ready = (rng[1:0] != 2'b00);  // stall about one cycle in four
      if (!in_valid && n < NUM_BUNDLES && rng[4:2] != 3'b000) begin
        in_valid = 1'b1;
        in_data  = bundle_words[n][w];
        if (w == IM_SHIFT_REGS - 1) begin
          in_user  = bundle_user[n];
          in_shift = bundle_shift[n];
          in_ones  = bundle_ones[n];
        end else begin
          in_user  = rng[11:8];  // junk, only the last word's sideband counts
          in_shift = kh_count_t'(rng[12]);
          in_ones  = rng[14];
        end
      end
      @(posedge aclk);
      took_word = in_valid && in_ready;
      if (took_word) begin
        w++;
        if (w == IM_SHIFT_REGS) begin
          w = 0;
          n++;
        end
      end
      @(negedge aclk);
    end
    in_valid  = 1'b0;
    out_ready = 1'b1;
    repeat (DRAIN_CYCLES) @(negedge aclk);  // any extra beat would hit the empty queue
    if (pixel_path_top_i.pixel_path_checker_i.failed) begin
      $display("a protocol assertion on the DUT ports failed");
      stop_on_error();
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
